/* design/rtg_fetch_timer.sv */
// Assumes pixel_width and extend stay stable during a line; the native strobe ignores blanking
`timescale 1ns/1ps

module rtg_fetch_timer
	import rtg_pkg::*;
(
	input  logic            CLK_114,
	input  logic            reset,
	input  logic            rtg_ena,     // RTG screen on
	input  logic            extend,      // One extra fetch clock past blank
	input  logic            low_scan,    // Halve native strobe period
	input  logic            line_blank,  // Stretched vblank or hblank
	input  logic [PW_W-1:0] pixel_width, // Clocks per fetch minus one
	output logic            fetch,       // Pop next word from FIFO
	output logic            native_strobe
);

	logic [PW_W-1:0]     pix_ctr;    // Compared against pixel_width
	logic                blank_d;    // Previous line_blank for extension
	logic [NATIVE_W-1:0] native_ctr; // Free-running native divider

	////////////////////
	// Fetch strobe
	////////////////////

	// Active area may run one clock past the start of blank when extend is set
	assign fetch = rtg_ena && (!line_blank || (!blank_d && extend)) &&
		(pix_ctr == pixel_width);

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			pix_ctr <= '0;
			blank_d <= 1'b0;
		end else begin
			blank_d <= line_blank; // Delayed copy
			if (line_blank || fetch) begin
				pix_ctr <= '0; // Restart the pixel period
			end else begin
				pix_ctr <= pix_ctr + 1'b1;
			end
		end
	end

	////////////////////
	// Native strobe
	////////////////////

	assign native_strobe = (native_ctr == '0);

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			native_ctr <= '0;
		end else if (low_scan) begin
			native_ctr <= {native_ctr[NATIVE_W-1:1], 1'b0} + NATIVE_W'(2); // Even steps only
		end else begin
			native_ctr <= native_ctr + 1'b1;
		end
	end

	// Counter stays inside one pixel period while an RTG line is active
	a_ctr_in_period : assert property (@(posedge CLK_114) disable iff (reset)
		(rtg_ena && !line_blank) |-> (pix_ctr <= pixel_width));

endmodule

/* design/rtg_pixel_format.sv */
// Colour and sync outputs lag inputs by one clock; OSD mix is combinational on the registered colour
`timescale 1ns/1ps

module rtg_pixel_format
	import rtg_pkg::*;
(
	input  logic              CLK_114,
	input  logic              reset,
	input  logic              rtg_ena,
	input  logic              line_blank,
	input  logic              fetch,         // New RTG word available
	input  logic              native_strobe,
	input  logic              hsync_in,
	input  logic              vsync_in,
	input  logic              csync_in,
	input  logic              osd_window,    // OSD area active
	input  logic              osd_pixel,     // OSD foreground pixel
	input  logic [PIX_W-1:0]  head_word,     // RGB555 word from FIFO
	input  logic [CHAN_W-1:0] native_r,
	input  logic [CHAN_W-1:0] native_g,
	input  logic [CHAN_W-1:0] native_b,
	output logic              pixel_strobe,  // One pulse per output pixel
	output logic              vga_hs,
	output logic              vga_vs,
	output logic              vga_cs,
	output logic [CHAN_W-1:0] vga_r,
	output logic [CHAN_W-1:0] vga_g,
	output logic [CHAN_W-1:0] vga_b
);

	pix_src_e          src;
	logic [CHAN_W-1:0] red_q;   // Registered colour
	logic [CHAN_W-1:0] green_q;
	logic [CHAN_W-1:0] blue_q;
	logic [1:0]        osd_r;   // OSD top bits
	logic [1:0]        osd_g;
	logic [1:0]        osd_b;

	always_comb begin
		if (!rtg_ena) src = SRC_NATIVE;
		else if (line_blank) src = SRC_BLANK;
		else src = SRC_RTG;
	end

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			red_q        <= '0;
			green_q      <= '0;
			blue_q       <= '0;
			pixel_strobe <= 1'b0;
		end else begin
			pixel_strobe <= rtg_ena ? fetch : native_strobe;
			case (src)
				SRC_NATIVE: begin
					red_q   <= native_r;
					green_q <= native_g;
					blue_q  <= native_b;
				end
				SRC_BLANK: begin
					red_q   <= '0;
					green_q <= '0;
					blue_q  <= '0;
				end
				default: begin
					if (fetch) begin // Low bits repeat the channel MSBs
						red_q   <= {head_word[14:10], head_word[14:12]};
						green_q <= {head_word[9:5], head_word[9:7]};
						blue_q  <= {head_word[4:0], head_word[4:2]};
					end
				end
			endcase
		end
	end

	always_ff @(posedge CLK_114) begin
		vga_hs <= hsync_in; // Match colour latency
		vga_vs <= vsync_in;
		vga_cs <= csync_in;
	end

	////////////////////
	// OSD overlay
	////////////////////

	assign osd_r = osd_pixel ? OSD_PIX_R : OSD_BG_R;
	assign osd_g = osd_pixel ? OSD_PIX_G : OSD_BG_G;
	assign osd_b = osd_pixel ? OSD_PIX_B : OSD_BG_B;

	assign vga_r = osd_window ? {osd_r, red_q[CHAN_W-1:2]} : red_q;
	assign vga_g = osd_window ? {osd_g, green_q[CHAN_W-1:2]} : green_q;
	assign vga_b = osd_window ? {osd_b, blue_q[CHAN_W-1:2]} : blue_q;

endmodule

/* design/rtg_pkg.sv */
// Widths and constants for the RTG video path; FIFO_DEPTH must be 2**FIFO_AW and NATIVE_DIV a power of two
package rtg_pkg;

	////////////////////
	// Data widths
	////////////////////

	localparam int PIX_W  = 16; // One hi-colour RGB555 word
	localparam int CHAN_W = 8;  // Per-channel output width
	localparam int PW_W   = 4;  // Clocks per fetch minus one
	localparam int VB_W   = 7;  // Stretch line count

	////////////////////
	// Word FIFO
	////////////////////

	localparam int FIFO_DEPTH    = 16;
	localparam int FIFO_AW       = 4;  // Pointer width
	localparam int FIFO_LOW_MARK = 8;  // Refill at or below this level

	////////////////////
	// Native strobe
	////////////////////

	// Full-rate period; low-scan mode steps by two and halves it
	localparam int NATIVE_DIV = 8;
	localparam int NATIVE_W   = $clog2(NATIVE_DIV); // Wraps at NATIVE_DIV

	////////////////////
	// OSD colours
	////////////////////

	// Top two bits of each channel where an OSD pixel is set
	localparam logic [1:0] OSD_PIX_R = 2'b11;
	localparam logic [1:0] OSD_PIX_G = 2'b11;
	localparam logic [1:0] OSD_PIX_B = 2'b11;

	// OSD background, a dark blue tint
	localparam logic [1:0] OSD_BG_R = 2'b00;
	localparam logic [1:0] OSD_BG_G = 2'b00;
	localparam logic [1:0] OSD_BG_B = 2'b10;

	////////////////////
	// Colour source
	////////////////////

	typedef enum logic [1:0] {
		SRC_NATIVE, // Chipset colour passes through
		SRC_BLANK,  // RTG blanking, black
		SRC_RTG     // Expanded hi-colour word
	} pix_src_e;

endpackage

/* design/rtg_vblank_stretch.sv */
// Stretch count is taken from hsync_in rising edges sampled in CLK_114; vbend must stay stable outside vblank
`timescale 1ns/1ps

module rtg_vblank_stretch
	import rtg_pkg::*;
(
	input  logic            CLK_114,
	input  logic            reset,
	input  logic            vblank,    // Chipset vertical blank
	input  logic            hblank,    // Chipset horizontal blank
	input  logic            hsync_in,  // Chipset hsync level
	input  logic [VB_W-1:0] vbend,     // Extra blank lines after vblank
	output logic            line_blank // RTG blank for fetch and colour
);

	logic            stretch;  // Extended vertical blank flag
	logic [VB_W-1:0] line_ctr; // Lines counted since vblank fell
	logic            hs_d;     // Registered hsync for edge detect

	////////////////////
	// Stretch counter
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			stretch  <= 1'b0;
			line_ctr <= '0;
			hs_d     <= 1'b0;
		end else begin
			hs_d <= hsync_in;
			if (vblank) begin
				stretch  <= 1'b1; // Hold blank through chipset vblank
				line_ctr <= '0;
			end else if (line_ctr == vbend) begin
				stretch <= 1'b0; // Enough lines, open the display
			end else if (hsync_in && !hs_d) begin
				line_ctr <= line_ctr + 1'b1; // New line started
			end
		end
	end

	// Combinational from the flag so fetch sees blank the same clock
	assign line_blank = stretch | hblank;

	// Count never overshoots the programmed end while blank is stretched
	a_ctr_bound : assert property (@(posedge CLK_114) disable iff (reset)
		stretch |-> (line_ctr <= vbend));

endmodule

/* design/rtg_video_top.sv */
// Single CLK_114 domain; memory answers word_req with one-clock fill strobes and has no back-pressure
`timescale 1ns/1ps

module rtg_video_top
	import rtg_pkg::*;
(
	input  logic              CLK_114,
	input  logic              reset,
	input  logic              rtg_ena,     // RTG screen on
	input  logic [PW_W-1:0]   pixel_width, // Clocks per fetch minus one
	input  logic [VB_W-1:0]   vbend,       // Extra blank lines
	input  logic              extend,
	input  logic              low_scan,
	input  logic              hblank,      // Chipset timing
	input  logic              vblank,
	input  logic              hsync_in,
	input  logic              vsync_in,
	input  logic              csync_in,
	input  logic [CHAN_W-1:0] native_r,    // Chipset colour
	input  logic [CHAN_W-1:0] native_g,
	input  logic [CHAN_W-1:0] native_b,
	input  logic              osd_window,
	input  logic              osd_pixel,
	input  logic              fill,        // Memory fill strobe
	input  logic [PIX_W-1:0]  fill_data,
	output logic              word_req,    // Refill request
	output logic              underrun,
	output logic              pixel_strobe,
	output logic [CHAN_W-1:0] vga_r,
	output logic [CHAN_W-1:0] vga_g,
	output logic [CHAN_W-1:0] vga_b,
	output logic              vga_hs,
	output logic              vga_vs,
	output logic              vga_cs
);

	logic             line_blank;    // Stretched blank
	logic             fetch;         // Word pop strobe
	logic             native_strobe;
	logic [PIX_W-1:0] head_word;     // FIFO head

	rtg_vblank_stretch i_rtg_vblank_stretch (
		.CLK_114    (CLK_114),
		.reset      (reset),
		.vblank     (vblank),
		.hblank     (hblank),
		.hsync_in   (hsync_in),
		.vbend      (vbend),
		.line_blank (line_blank)
	);

	rtg_fetch_timer i_rtg_fetch_timer (
		.CLK_114       (CLK_114),
		.reset         (reset),
		.rtg_ena       (rtg_ena),
		.extend        (extend),
		.low_scan      (low_scan),
		.line_blank    (line_blank),
		.pixel_width   (pixel_width),
		.fetch         (fetch),
		.native_strobe (native_strobe)
	);

	rtg_word_fifo i_rtg_word_fifo (
		.CLK_114   (CLK_114),
		.reset     (reset),
		.rtg_ena   (rtg_ena),
		.vblank    (vblank),
		.fill      (fill),
		.fill_data (fill_data),
		.fetch     (fetch),
		.head_word (head_word),
		.word_req  (word_req),
		.underrun  (underrun)
	);

	rtg_pixel_format i_rtg_pixel_format (
		.CLK_114       (CLK_114),
		.reset         (reset),
		.rtg_ena       (rtg_ena),
		.line_blank    (line_blank),
		.fetch         (fetch),
		.native_strobe (native_strobe),
		.hsync_in      (hsync_in),
		.vsync_in      (vsync_in),
		.csync_in      (csync_in),
		.osd_window    (osd_window),
		.osd_pixel     (osd_pixel),
		.head_word     (head_word),
		.native_r      (native_r),
		.native_g      (native_g),
		.native_b      (native_b),
		.pixel_strobe  (pixel_strobe),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs),
		.vga_cs        (vga_cs),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b)
	);

endmodule

/* design/rtg_word_fifo.sv */
// Fill has no back-pressure and a fill into a full FIFO is dropped; underrun clears only on reset
`timescale 1ns/1ps

module rtg_word_fifo
	import rtg_pkg::*;
(
	input  logic             CLK_114,
	input  logic             reset,
	input  logic             rtg_ena,   // Flush while RTG is off
	input  logic             vblank,    // Flush during chipset vblank
	input  logic             fill,      // Single-cycle write strobe
	input  logic [PIX_W-1:0] fill_data,
	input  logic             fetch,     // Pop head word
	output logic [PIX_W-1:0] head_word, // Word at read pointer
	output logic             word_req,  // Refill request level
	output logic             underrun   // Sticky on a fetch while empty
);

	logic [PIX_W-1:0]   mem [FIFO_DEPTH]; // Word storage
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   level;  // 0 to FIFO_DEPTH
	logic               flush;
	logic               full;
	logic               empty;
	logic               push;
	logic               pop;

	assign flush = vblank || !rtg_ena;
	assign full  = (level == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty = (level == '0);
	assign push  = fill && !full;  // Dropped when full
	assign pop   = fetch && !empty;

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (push) begin
			mem[wr_ptr] <= fill_data;
		end
	end

	assign head_word = mem[rd_ptr];

	////////////////////
	// Pointers and level
	////////////////////

	always_ff @(posedge CLK_114) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1; // Wraps at FIFO_DEPTH
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level; // Both or neither
			endcase
		end
	end

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			underrun <= 1'b0;
		end else if (fetch && empty) begin
			underrun <= 1'b1; // Display outran memory
		end
	end

	// Ask for more words once at or below the low mark
	assign word_req = (level <= (FIFO_AW+1)'(FIFO_LOW_MARK)) && rtg_ena && !vblank;

	// Pointer distance agrees with the level count over any fill and fetch sequence
	a_level_ptrs : assert property (@(posedge CLK_114) disable iff (reset)
		(wr_ptr - rd_ptr) == level[FIFO_AW-1:0]);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the RTG video testbench with Verilator and run it.
# The exit status follows the pass line in the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module rtg_video_tb \
	-o rtg_video_sim

./obj_dir/rtg_video_sim | tee sim.log

if grep -q "^No errors$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* verification/rtg_video_tb.sv */
// Table-driven testbench for the RTG video path; the FIFO model assumes no fill during a line
`timescale 1ns/1ps

module rtg_video_tb
	import rtg_pkg::*;
();

	////////////////////
	// DUT signals
	////////////////////

	logic              CLK_114;
	logic              reset;
	logic              rtg_ena, extend, low_scan;
	logic [PW_W-1:0]   pixel_width;
	logic [VB_W-1:0]   vbend;
	logic              hblank, vblank, hsync_in, vsync_in, csync_in;
	logic [CHAN_W-1:0] native_r, native_g, native_b;
	logic              osd_window, osd_pixel;
	logic              fill;
	logic [PIX_W-1:0]  fill_data;
	logic              word_req, underrun, pixel_strobe;
	logic [CHAN_W-1:0] vga_r, vga_g, vga_b;
	logic              vga_hs, vga_vs, vga_cs;

	rtg_video_top i_rtg_video_top (.*);

	////////////////////
	// Case table
	////////////////////

	typedef struct packed {
		logic [79:0]     name;    // Ten characters
		logic            rtg;
		logic [PW_W-1:0] pw;
		logic [VB_W-1:0] vb;
		logic            ext;
		logic            low;
		logic            win;     // OSD window
		logic            opix;    // OSD pixel
		logic [23:0]     native;  // Native colour mixed with noise
		logic [7:0]      n_words; // Words filled or clocks in native mode
		logic [7:0]      n_fetch; // Fetches in the active line
	} case_t;

	localparam int N_CASES = 9;
	localparam case_t CASES [N_CASES] = '{
		'{"hicol_pw_3", 1'b1, 4'd3, 7'd0, 1'b0, 1'b0, 1'b0, 1'b0, 24'h000000, 8'd12, 8'd12},
		'{"hicol_pw_0", 1'b1, 4'd0, 7'd0, 1'b0, 1'b0, 1'b0, 1'b0, 24'h000000, 8'd10, 8'd10},
		'{"hicol_ext6", 1'b1, 4'd6, 7'd0, 1'b1, 1'b0, 1'b0, 1'b0, 24'h000000, 8'd8,  8'd8},
		'{"stretch_v3", 1'b1, 4'd2, 7'd3, 1'b0, 1'b0, 1'b0, 1'b0, 24'h000000, 8'd16, 8'd16},
		'{"native_osd", 1'b0, 4'd0, 7'd0, 1'b0, 1'b0, 1'b1, 1'b1, 24'h5A3CC3, 8'd40, 8'd0},
		'{"native_low", 1'b0, 4'd0, 7'd0, 1'b0, 1'b1, 1'b1, 1'b0, 24'h81F00F, 8'd40, 8'd0},
		'{"native_raw", 1'b0, 4'd0, 7'd0, 1'b0, 1'b0, 1'b0, 1'b0, 24'h123456, 8'd24, 8'd0},
		'{"underrun_1", 1'b1, 4'd1, 7'd1, 1'b0, 1'b0, 1'b0, 1'b0, 24'h000000, 8'd4,  8'd7},
		'{"hicol_osd2", 1'b1, 4'd2, 7'd0, 1'b0, 1'b0, 1'b1, 1'b0, 24'h000000, 8'd6,  8'd6}
	};

	string       cur_name;     // Case label for error lines
	int          errors;
	logic [15:0] lfsr_state;
	logic        exp_underrun; // Sticky until reset
	logic        hs_prev, vs_prev, cs_prev;

	initial begin
		CLK_114 = 1'b0;
		forever #5 CLK_114 = ~CLK_114; // 10 ns period
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // Taps 16,14,13,11
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state); // One step per bit
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [23:0] expand555(input logic [15:0] w);
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
		r = w[14:10];
		g = w[9:5];
		b = w[4:0];
		return {r, r[4:2], g, g[4:2], b, b[4:2]}; // MSBs repeated below
	endfunction

	function automatic logic [23:0] osd_mix(input logic [23:0] c, input logic win,
		input logic opix);
		logic [1:0] tr;
		logic [1:0] tg;
		logic [1:0] tb;
		tr = opix ? OSD_PIX_R : OSD_BG_R;
		tg = opix ? OSD_PIX_G : OSD_BG_G;
		tb = opix ? OSD_PIX_B : OSD_BG_B;
		return win ? {tr, c[23:18], tg, c[15:10], tb, c[7:2]} : c;
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Stopped at first failing check");
	endtask

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			report_fail($sformatf("** Error %s %s: expected %0h, actual %0h", cur_name, what,
				exp, act));
		end
	endtask

	task automatic next_cycle();
		logic [31:0] bits;
		@(posedge CLK_114);
		#1; // Drive after the edge
		rand_bits(2, bits);
		vsync_in = bits[1];
		csync_in = bits[0];
	endtask

	task automatic sample_cycle();
		@(negedge CLK_114); // Mid-cycle once all outputs have settled
		check_eq("vga_hs", 32'(hs_prev), 32'(vga_hs));
		check_eq("vga_vs", 32'(vs_prev), 32'(vga_vs));
		check_eq("vga_cs", 32'(cs_prev), 32'(vga_cs));
		hs_prev = hsync_in;
		vs_prev = vsync_in;
		cs_prev = csync_in;
	endtask

	task automatic apply_config(input case_t c);
		rtg_ena     = c.rtg;
		pixel_width = c.pw;
		vbend       = c.vb;
		extend      = c.ext;
		low_scan    = c.low;
		osd_window  = c.win;
		osd_pixel   = c.opix;
	endtask

	task automatic check_blank(input case_t c, input int level);
		check_eq("pixel_strobe in blank", 0, 32'(pixel_strobe));
		check_eq("colour in blank", 32'(osd_mix(24'h0, c.win, c.opix)),
			32'({vga_r, vga_g, vga_b}));
		check_eq("word_req", 32'(level <= FIFO_LOW_MARK), 32'(word_req));
		check_eq("underrun", 32'(exp_underrun), 32'(underrun));
	endtask

	////////////////////
	// RTG case
	////////////////////

	task automatic run_rtg_case(input case_t c);
		logic [15:0] words [$]; // FIFO model in fill order
		logic [15:0] w;
		logic [23:0] exp_col;
		logic        col_known, prev_hb, strobe_due, popped;
		int          lim;
		for (int i = 0; i < 3; i++) begin // Chipset vblank flushes the FIFO
			next_cycle();
			apply_config(c);
			{native_r, native_g, native_b} = c.native;
			vblank = 1'b1;
			hblank = 1'b1;
			hsync_in = 1'b0;
			fill = 1'b0;
			sample_cycle();
			check_eq("word_req in vblank", 0, 32'(word_req));
		end
		for (int i = 0; i < int'(c.n_words); i++) begin // Fill behind hblank
			logic [31:0] bits;
			next_cycle();
			vblank = 1'b0;
			rand_bits(16, bits);
			fill = 1'b1;
			fill_data = bits[15:0];
			sample_cycle();
			check_blank(c, words.size());
			words.push_back(fill_data);
		end
		for (int i = 0; i < 2 * int'(c.vb); i++) begin // Stretch lines
			next_cycle();
			fill = 1'b0;
			hblank = 1'b0;
			hsync_in = (i % 2 == 0); // Rising edge every other clock
			sample_cycle();
			check_blank(c, words.size());
		end
		lim = int'(c.n_fetch) * (int'(c.pw) + 1);
		exp_col = '0;
		col_known = 1'b1;
		prev_hb = 1'b1; // Stretch or hblank before the line
		for (int t = 0; t <= lim; t++) begin
			next_cycle();
			fill = 1'b0;
			hsync_in = 1'b0;
			hblank = (t >= lim - int'(c.ext)); // Extend fetches one clock into hblank
			sample_cycle();
			strobe_due = (t > 0) && (t % (int'(c.pw) + 1) == 0);
			popped = 1'b0;
			if (strobe_due) begin
				if (words.size() == 0) begin
					exp_underrun = 1'b1; // Fetch on empty FIFO
				end else begin
					w = words.pop_front();
					popped = 1'b1;
				end
			end
			if (prev_hb) begin
				exp_col = '0; // Blank loads black whether or not it fetched
				col_known = 1'b1;
			end else if (strobe_due) begin
				exp_col = expand555(w);
				col_known = popped; // Stale head after underrun
			end
			prev_hb = hblank;
			check_eq("pixel_strobe", 32'(strobe_due), 32'(pixel_strobe));
			check_eq("underrun", 32'(exp_underrun), 32'(underrun));
			check_eq("word_req", 32'(words.size() <= FIFO_LOW_MARK), 32'(word_req));
			if (col_known) begin
				check_eq("colour", 32'(osd_mix(exp_col, c.win, c.opix)),
					32'({vga_r, vga_g, vga_b}));
			end
		end
	endtask

	////////////////////
	// Native case
	////////////////////

	task automatic run_native_case(input case_t c);
		logic [31:0] bits;
		logic [23:0] prev_native;
		int          period, last_t;
		period = c.low ? NATIVE_DIV / 2 : NATIVE_DIV;
		last_t = -1;
		prev_native = '0;
		for (int t = 0; t < int'(c.n_words); t++) begin
			next_cycle();
			apply_config(c);
			vblank = 1'b0;
			hblank = 1'b0;
			fill = 1'b0;
			rand_bits(24, bits);
			{native_r, native_g, native_b} = bits[23:0] ^ c.native;
			rand_bits(1, bits);
			hsync_in = bits[0];
			sample_cycle();
			if (t > 0) begin // First clock still shows RTG colour
				check_eq("native colour", 32'(osd_mix(prev_native, c.win, c.opix)),
					32'({vga_r, vga_g, vga_b}));
			end
			prev_native = {native_r, native_g, native_b};
			check_eq("word_req", 0, 32'(word_req));
			check_eq("underrun", 32'(exp_underrun), 32'(underrun));
			if (t > NATIVE_DIV && pixel_strobe) begin // Divider phase settled
				if (last_t >= 0) begin
					check_eq("native strobe period", 32'(period), 32'(t - last_t));
				end
				last_t = t;
			end else if (t > NATIVE_DIV && last_t >= 0) begin
				assert ((t - last_t) < period) else begin
					report_fail($sformatf("%s: no pixel strobe for %0d clocks in native mode",
						cur_name, t - last_t));
				end
			end
		end
		assert (last_t >= 0) else begin
			report_fail($sformatf("%s: native mode produced no pixel strobe", cur_name));
		end
	endtask

	////////////////////
	// Watchdog
	////////////////////

	function automatic int watchdog_cycles();
		int total;
		total = 100; // Reset and slack
		for (int i = 0; i < N_CASES; i++) begin
			total += int'(CASES[i].n_fetch) * (int'(CASES[i].pw) + 1);
			total += int'(CASES[i].n_words) + 2 * int'(CASES[i].vb) + 8;
		end
		return total;
	endfunction

	initial begin
		repeat (watchdog_cycles()) @(posedge CLK_114);
		$display("Errors found");
		$fatal(1, "Simulation timed out before all cases finished");
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		lfsr_state = 16'd56762;
		errors = 0;
		exp_underrun = 1'b0;
		{hs_prev, vs_prev, cs_prev} = '0;
		reset = 1'b1;
		{rtg_ena, extend, low_scan, pixel_width, vbend} = '0;
		{hblank, vblank, hsync_in, vsync_in, csync_in} = '0;
		{native_r, native_g, native_b, osd_window, osd_pixel} = '0;
		fill = 1'b0;
		fill_data = '0;
		repeat (3) @(posedge CLK_114); // Three reset clocks
		#1;
		reset = 1'b0;
		cur_name = "reset";
		sample_cycle();
		check_eq("pixel_strobe", 0, 32'(pixel_strobe));
		check_eq("word_req", 0, 32'(word_req));
		check_eq("underrun", 0, 32'(underrun));
		check_eq("colour", 0, 32'({vga_r, vga_g, vga_b}));
		for (int i = 0; i < N_CASES; i++) begin
			cur_name = $sformatf("%s", CASES[i].name);
			if (CASES[i].rtg) begin
				run_rtg_case(CASES[i]);
			end else begin
				run_native_case(CASES[i]);
			end
		end
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* vlog.f */
design/rtg_pkg.sv
design/rtg_fetch_timer.sv
design/rtg_vblank_stretch.sv
design/rtg_word_fifo.sv
design/rtg_pixel_format.sv
design/rtg_video_top.sv
verification/rtg_video_tb.sv
